// ==== project.f ====
+incdir+.
sd_spi_pkg.sv
sd_loader_pkg.sv
spi_byte_shifter.sv
sd_block_reader.sv
sd_ram_loader.sv
sd_ram_loader_top.sv
tb_sd_card_model.sv
sd_ram_loader_properties.sv
tb_sd_ram_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_sd_ram_loader -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
fi
exit 1

// ==== sd_block_reader.sv ====
`timescale 1ns/10ps
`include "sd_loader_params.svh"

module sd_block_reader import sd_spi_pkg::*; (
	input  logic        clk50,
	input  logic        reset,
	input  logic        rd_i,         // block read request
	input  logic [31:0] addr_i,       // cmd17 argument
	output logic        busy_o,
	output logic [7:0]  byte_o,
	output logic        byte_rdy_o,
	input  logic        byte_ack_i,
	output sd_err_t     error_o,
	output logic        cs_bo,
	output logic        xfer_o,       // to shifter
	output logic [7:0]  tx_byte_o,
	input  logic [7:0]  rx_byte_i,
	input  logic        shift_done_i
);

	sd_rd_state_t state;
	sd_cmd_t      cmd_q;      // command in flight, decides what its r1 means
	logic [31:0]  arg_q;
	logic [9:0]   cnt;        // dummy bytes, frame bytes, polls or data bytes
	logic [3:0]   tries;      // acmd41 attempts
	logic         wait_q;     // shifter exchange outstanding
	logic         wants_byte;
	logic [7:0]   next_tx;

	function automatic logic [7:0] frame_byte(input sd_cmd_t cmd, input logic [31:0] arg,
			input logic [2:0] idx);
		logic [7:0] b;
		case (idx)
			3'd0: b = {2'b01, cmd}; // start and transmission bits
			3'd1: b = arg[31:24];
			3'd2: b = arg[23:16];
			3'd3: b = arg[15:8];
			3'd4: b = arg[7:0];
			default: b = (cmd == CMD_GO_IDLE) ? 8'h95 : 8'h01; // fixed crc for cmd0 else stop bit
		endcase
		return b;
	endfunction

	assign wants_byte = (state == RD_POWERUP) || (state == RD_CMD) || (state == RD_R1) ||
		(state == RD_TOKEN) || (state == RD_DATA) || (state == RD_CRC);
	assign next_tx = (state == RD_CMD) ? frame_byte(cmd_q, arg_q, cnt[2:0]) : 8'hFF;

	always_ff @(posedge clk50) begin
		xfer_o <= 1'b0; // strobe
		if (reset) begin
			state <= RD_POWERUP;
			cmd_q <= CMD_GO_IDLE;
			cnt <= '0;
			tries <= '0;
			wait_q <= 1'b0;
			busy_o <= 1'b1; // busy through bring-up
			byte_rdy_o <= 1'b0;
			error_o <= ERR_NONE;
			cs_bo <= 1'b1;
			tx_byte_o <= 8'hFF;
		end else begin
			if (wants_byte && !wait_q) begin // launch next exchange
				xfer_o <= 1'b1;
				tx_byte_o <= next_tx;
				wait_q <= 1'b1;
			end else if (shift_done_i) begin
				wait_q <= 1'b0;
			end
			case (state)
				RD_POWERUP: if (shift_done_i) begin // 10 bytes = 80 clocks, cs high
					cnt <= (cnt == 10'd9) ? '0 : cnt + 10'd1;
					if (cnt == 10'd9) begin
						cs_bo <= 1'b0;
						arg_q <= '0;
						state <= RD_CMD;
					end
				end
				RD_CMD: if (shift_done_i) begin // six byte frame
					cnt <= (cnt == 10'd5) ? '0 : cnt + 10'd1;
					if (cnt == 10'd5)
						state <= RD_R1;
				end
				RD_R1: if (shift_done_i) begin
					cnt <= cnt + 10'd1;
					if (rx_byte_i != 8'hFF || cnt == 10'd15) begin // answer or 16 polls gone
						cnt <= '0;
						state <= RD_CMD; // most outcomes send another command
						case (cmd_q)
							CMD_GO_IDLE: if (rx_byte_i == R1_IDLE) begin
								cmd_q <= CMD_APP;
							end else begin
								error_o <= ERR_CMD0;
								state <= RD_FAIL;
							end
							CMD_APP: begin
								cmd_q <= ACMD_SEND_OP;
								arg_q <= 32'h4000_0000; // hcs, host takes high capacity
							end
							ACMD_SEND_OP: if (rx_byte_i == R1_READY) begin
								busy_o <= 1'b0; // bring-up ok, error stays none
								cs_bo <= 1'b1;
								state <= RD_IDLE;
							end else if (tries == 4'(`SDL_INIT_TRIES - 1)) begin
								error_o <= ERR_INIT_TIMEOUT;
								state <= RD_FAIL;
							end else begin
								tries <= tries + 4'd1;
								cmd_q <= CMD_APP;
								arg_q <= '0;
							end
							default: if (rx_byte_i == R1_READY) begin // cmd17 accepted
								state <= RD_TOKEN;
							end else begin
								error_o <= ERR_READ_RESP;
								state <= RD_FAIL;
							end
						endcase
					end
				end
				RD_IDLE: if (rd_i) begin
					arg_q <= addr_i;
					cmd_q <= CMD_READ_BLOCK;
					busy_o <= 1'b1; // held until crc bytes are gone
					cs_bo <= 1'b0;
					state <= RD_CMD;
				end
				RD_TOKEN: if (shift_done_i) begin
					cnt <= cnt + 10'd1;
					if (rx_byte_i == DATA_TOKEN) begin
						cnt <= '0;
						state <= RD_DATA;
					end else if (cnt == 10'd1023) begin // token never came
						error_o <= ERR_READ_RESP;
						state <= RD_FAIL;
					end
				end
				RD_DATA: if (shift_done_i) begin
					byte_o <= rx_byte_i;
					byte_rdy_o <= 1'b1;
					state <= RD_HANDSHAKE;
				end
				RD_HANDSHAKE: if (byte_rdy_o && byte_ack_i) begin
					byte_rdy_o <= 1'b0;
				end else if (!byte_rdy_o && !byte_ack_i) begin // loader released ack
					cnt <= (cnt == 10'(`SDL_BLOCK_BYTES - 1)) ? '0 : cnt + 10'd1;
					state <= (cnt == 10'(`SDL_BLOCK_BYTES - 1)) ? RD_CRC : RD_DATA;
				end
				RD_CRC: if (shift_done_i) begin // two crc bytes, discarded
					cnt <= cnt + 10'd1;
					if (cnt == 10'd1) begin
						cnt <= '0;
						busy_o <= 1'b0; // end of block
						cs_bo <= 1'b1;
						state <= RD_IDLE;
					end
				end
				RD_FAIL: cs_bo <= 1'b1; // card unusable, busy stays high
				default: state <= RD_FAIL;
			endcase
		end
	end

endmodule

// ==== sd_loader_params.svh ====
`ifndef SD_LOADER_PARAMS_SVH
`define SD_LOADER_PARAMS_SVH

// ram word packing
`define SDL_WORD_BYTES 16 // card bytes per ram word
`define SDL_WORD_BITS 128
`define SDL_ADDR_BITS 22

// card side
`define SDL_BLOCK_BYTES 512 // one cmd17 transfer
`define SDL_INIT_TRIES 8 // acmd41 attempts before giving up

// load range
`define SDL_RAM_WORDS 64 // two blocks by default
`define SDL_RAM_BASE 22'h000100 // first word address written

// sclk half period in clk50 cycles, kept small for simulation
`define SDL_CLK_DIV 2

`endif

// ==== sd_loader_pkg.sv ====
`include "sd_loader_params.svh"

package sd_loader_pkg;

	typedef logic [`SDL_WORD_BITS-1:0] ram_word_t; // 16 card bytes, first byte in the low lane
	typedef logic [`SDL_ADDR_BITS-1:0] ram_addr_t; // word address

	typedef enum logic [2:0] {
		WAIT_CARD,   // card bring-up still running
		START_BLOCK, // rd held until the reader goes busy
		GET_BYTE,
		ACK_BYTE,
		WRITE_WORD,  // we held until op_begun
		ERROR,
		DONE
	} ldr_state_t;

endpackage

// ==== sd_ram_loader.sv ====
`timescale 1ns/10ps
`include "sd_loader_params.svh"

module sd_ram_loader import sd_loader_pkg::*, sd_spi_pkg::*; #(
	parameter bit sdhc = 1'b1 // block index argument, else byte address
) (
	input  logic        clk50,
	input  logic        reset,
	output logic        sd_rd_o,
	output logic [31:0] sd_addr_o,
	input  logic        sd_busy_i,
	input  logic [7:0]  sd_byte_i,
	input  logic        sd_byte_rdy_i,
	output logic        sd_byte_ack_o,
	input  sd_err_t     sd_error_i,
	output logic        ram_we_o,
	output ram_addr_t   ram_addr_o,
	output ram_word_t   ram_data_o,
	input  logic        ram_op_begun_i, // ram took the word
	output logic        done_o,
	output logic        error_o
);

	localparam int idx_bits = $clog2(`SDL_WORD_BYTES);
	localparam int words_per_block = `SDL_BLOCK_BYTES / `SDL_WORD_BYTES;

	ldr_state_t            state_r, state_x;
	ram_addr_t             word_cnt_r, word_cnt_x; // words written so far
	logic [idx_bits-1:0]   byte_idx_r, byte_idx_x; // byte lane being filled
	ram_word_t             data_r, data_x;

	assign ram_addr_o = `SDL_RAM_BASE + word_cnt_r;
	assign ram_data_o = data_r;
	assign sd_addr_o = sdhc ? 32'(word_cnt_r) / words_per_block : 32'(word_cnt_r) * `SDL_WORD_BYTES;

	always_ff @(posedge clk50) begin
		data_r <= data_x;
		if (reset) begin
			state_r <= WAIT_CARD;
			word_cnt_r <= '0;
			byte_idx_r <= '0;
		end else begin
			state_r <= state_x;
			word_cnt_r <= word_cnt_x;
			byte_idx_r <= byte_idx_x;
		end
	end

	always_comb begin
		state_x = state_r;
		word_cnt_x = word_cnt_r;
		byte_idx_x = byte_idx_r;
		data_x = data_r;
		sd_rd_o = 1'b0;
		sd_byte_ack_o = 1'b0;
		ram_we_o = 1'b0;
		done_o = 1'b0;
		error_o = 1'b0;
		case (state_r)
			WAIT_CARD: begin // failure keeps busy high so look at the code first
				if (sd_error_i != ERR_NONE)
					state_x = ERROR;
				else if (!sd_busy_i)
					state_x = START_BLOCK;
			end
			START_BLOCK: begin
				sd_rd_o = 1'b1; // address follows the word counter
				if (sd_busy_i)
					state_x = GET_BYTE;
			end
			GET_BYTE: begin
				if (!sd_busy_i) begin // block ended, fetch the next one
					state_x = START_BLOCK;
				end else if (sd_byte_rdy_i) begin
					data_x[byte_idx_r*8 +: 8] = sd_byte_i;
					state_x = ACK_BYTE;
				end
			end
			ACK_BYTE: begin
				sd_byte_ack_o = 1'b1;
				if (!sd_byte_rdy_i) begin // reader saw the ack
					byte_idx_x = byte_idx_r + 1'b1; // wraps after the last lane
					if (byte_idx_r == idx_bits'(`SDL_WORD_BYTES - 1))
						state_x = WRITE_WORD;
					else
						state_x = GET_BYTE;
				end
			end
			WRITE_WORD: begin
				ram_we_o = 1'b1; // addr and data frozen meanwhile
				if (ram_op_begun_i) begin
					word_cnt_x = word_cnt_r + 1'b1;
					if (word_cnt_r == ram_addr_t'(`SDL_RAM_WORDS - 1))
						state_x = DONE;
					else
						state_x = GET_BYTE;
				end
			end
			ERROR: error_o = 1'b1;
			DONE: done_o = 1'b1;
			default: state_x = ERROR;
		endcase
	end

endmodule

// ==== sd_ram_loader_properties.sv ====
`timescale 1ns/10ps

module sd_ram_loader_properties import sd_loader_pkg::*; (
	input logic      clk50,
	input logic      reset,
	input logic      ram_we_o,
	input ram_addr_t ram_addr_o,
	input ram_word_t ram_data_o,
	input logic      ram_op_begun_i,
	input logic      done_o,
	input logic      error_o,
	input logic      sd_byte_ack_o,
	input logic      sd_byte_rdy_i
);

	// ram outputs frozen while the write waits for op_begun
	a_ram_hold: assert property (@(posedge clk50) disable iff (reset)
		ram_we_o && !ram_op_begun_i |=> $stable(ram_addr_o) && $stable(ram_data_o))
		else $error("ram address or data moved during a pending write");

	// done follows the last taken write and never shows up with error
	a_done_err: assert property (@(posedge clk50) disable iff (reset)
		!(done_o && error_o) && (!$rose(done_o) || $past(ram_we_o && ram_op_begun_i)))
		else $error("done and error both high or done without a final write");

	a_ack_rdy: assert property (@(posedge clk50) disable iff (reset)
		$rose(sd_byte_ack_o) |-> sd_byte_rdy_i)
		else $error("byte ack raised without byte ready");

endmodule

bind sd_ram_loader sd_ram_loader_properties props (.*);

// ==== sd_ram_loader_top.sv ====
`timescale 1ns/10ps

module sd_ram_loader_top import sd_loader_pkg::*, sd_spi_pkg::*; (
	input  logic      clk50,
	input  logic      reset,
	output logic      ram_we_o,
	output ram_addr_t ram_addr_o,
	output ram_word_t ram_data_o,
	input  logic      ram_op_begun_i,
	output logic      done_o,
	output logic      error_o,
	output logic      cs_bo,
	output logic      sclk_o,
	output logic      mosi_o,
	input  logic      miso_i
);

	logic        sd_rd;      // loader to reader
	logic [31:0] sd_addr;
	logic        sd_busy;
	logic [7:0]  sd_byte;
	logic        sd_byte_rdy;
	logic        sd_byte_ack;
	sd_err_t     sd_error;
	logic        xfer;       // reader to shifter
	logic [7:0]  tx_byte;
	logic [7:0]  rx_byte;
	logic        shift_done;

	sd_ram_loader u_loader (
		.clk50(clk50), .reset(reset),
		.sd_rd_o(sd_rd), .sd_addr_o(sd_addr), .sd_busy_i(sd_busy),
		.sd_byte_i(sd_byte), .sd_byte_rdy_i(sd_byte_rdy), .sd_byte_ack_o(sd_byte_ack),
		.sd_error_i(sd_error),
		.ram_we_o(ram_we_o), .ram_addr_o(ram_addr_o), .ram_data_o(ram_data_o),
		.ram_op_begun_i(ram_op_begun_i), .done_o(done_o), .error_o(error_o)
	);

	sd_block_reader u_reader (
		.clk50(clk50), .reset(reset),
		.rd_i(sd_rd), .addr_i(sd_addr), .busy_o(sd_busy),
		.byte_o(sd_byte), .byte_rdy_o(sd_byte_rdy), .byte_ack_i(sd_byte_ack),
		.error_o(sd_error), .cs_bo(cs_bo),
		.xfer_o(xfer), .tx_byte_o(tx_byte), .rx_byte_i(rx_byte), .shift_done_i(shift_done)
	);

	spi_byte_shifter u_shifter (
		.clk50(clk50), .reset(reset),
		.xfer_i(xfer), .tx_byte_i(tx_byte), .rx_byte_o(rx_byte), .done_o(shift_done),
		.sclk_o(sclk_o), .mosi_o(mosi_o), .miso_i(miso_i)
	);

endmodule

// ==== sd_spi_pkg.sv ====
package sd_spi_pkg;

	// 6-bit command index as sent after the 01 start bits
	typedef enum logic [5:0] {
		CMD_GO_IDLE    = 6'd0,
		CMD_READ_BLOCK = 6'd17,
		ACMD_SEND_OP   = 6'd41, // only valid right after cmd55
		CMD_APP        = 6'd55
	} sd_cmd_t;

	typedef enum logic [15:0] {
		ERR_NONE         = 16'h0000,
		ERR_CMD0         = 16'h0001, // card did not go idle
		ERR_INIT_TIMEOUT = 16'h0002, // acmd41 never returned ready
		ERR_READ_RESP    = 16'h0003  // cmd17 rejected or no token
	} sd_err_t;

	localparam logic [7:0] R1_IDLE    = 8'h01; // in idle state bit only
	localparam logic [7:0] R1_READY   = 8'h00;
	localparam logic [7:0] DATA_TOKEN = 8'hFE; // start of single block data

	typedef enum logic [3:0] {
		RD_POWERUP, RD_CMD, RD_R1, RD_IDLE, RD_TOKEN,
		RD_DATA, RD_HANDSHAKE, RD_CRC, RD_FAIL
	} sd_rd_state_t;

endpackage

// ==== spi_byte_shifter.sv ====
`timescale 1ns/10ps
`include "sd_loader_params.svh"

module spi_byte_shifter (
	input  logic       clk50,
	input  logic       reset,
	input  logic       xfer_i,    // one cycle start strobe
	input  logic [7:0] tx_byte_i, // sampled with xfer_i
	output logic [7:0] rx_byte_o,
	output logic       done_o,    // one cycle, rx_byte_o valid
	output logic       sclk_o,
	output logic       mosi_o,
	input  logic       miso_i
);

	logic [7:0] shreg;   // tx leaves at bit 7 and rx enters at bit 0
	logic [7:0] div_cnt; // position inside the sclk half period
	logic [2:0] bit_cnt; // rising edges so far, wraps to 0 after eight
	logic       active;  // byte in flight
	logic       half_end;

	assign half_end = (div_cnt == 8'(`SDL_CLK_DIV - 1));

	always_ff @(posedge clk50) begin
		done_o <= 1'b0; // strobe
		if (reset) begin
			active <= 1'b0;
			sclk_o <= 1'b0; // mode 0 idles low
			mosi_o <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (xfer_i) begin
			active <= 1'b1;
			shreg <= tx_byte_i;
			mosi_o <= tx_byte_i[7]; // msb valid before the first rising edge
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (active) begin
			div_cnt <= half_end ? '0 : div_cnt + 8'd1;
			if (half_end) begin
				sclk_o <= ~sclk_o;
				if (!sclk_o) begin // rising edge, sample miso
					shreg <= {shreg[6:0], miso_i};
					bit_cnt <= bit_cnt + 3'd1;
				end else if (bit_cnt == 3'd0) begin // falling edge after the 8th sample
					active <= 1'b0;
					done_o <= 1'b1;
					rx_byte_o <= shreg;
					mosi_o <= 1'b1; // back to idle high
				end else begin
					mosi_o <= shreg[7]; // next tx bit on falling edge
				end
			end
		end
	end

endmodule

// ==== tb_sd_card_model.sv ====
`timescale 1ns/10ps

module tb_sd_card_model import sd_spi_pkg::*; (
	input  logic        reset_i,
	input  logic        cs_b_i,
	input  logic        sclk_i,
	input  logic        mosi_i,
	output logic        miso_o,
	input  logic [7:0]  image_i [0:1023],  // card content, wraps past 1 KiB
	input  logic [7:0]  token_delay_i [0:7], // ff bytes before each data token
	input  logic [7:0]  cmd0_resp_i,
	input  logic [3:0]  acmd41_idle_i,     // acmd41 answers that stay idle
	output logic [3:0]  cmd17_cnt_o,
	output logic [31:0] cmd17_arg_o
);

	logic [7:0] rx_sh;
	logic [7:0] tx_sh = 8'hFF; // miso idles high
	logic [7:0] frame [0:5];
	logic [7:0] resp_q [$];    // bytes waiting to go out on miso
	int         bit_cnt;
	int         frame_cnt;
	int         idle_left;
	bit         app_cmd;       // last command was cmd55

	assign miso_o = tx_sh[7];

	task automatic run_cmd();
		logic [31:0] arg;
		int base;
		arg = {frame[1], frame[2], frame[3], frame[4]};
		resp_q.push_back(8'hFF); // one byte of ncr
		case (sd_cmd_t'(frame[0][5:0]))
			CMD_GO_IDLE: resp_q.push_back(cmd0_resp_i);
			CMD_APP: resp_q.push_back(R1_IDLE);
			ACMD_SEND_OP: if (app_cmd && idle_left > 0) begin
				resp_q.push_back(R1_IDLE);
				idle_left--;
			end else begin
				resp_q.push_back(app_cmd ? R1_READY : 8'h04);
			end
			CMD_READ_BLOCK: begin
				cmd17_arg_o = arg;
				resp_q.push_back(R1_READY);
				for (int i = 0; i < int'(token_delay_i[cmd17_cnt_o[2:0]]); i++)
					resp_q.push_back(8'hFF);
				resp_q.push_back(DATA_TOKEN);
				base = int'(arg) * 512; // block index addressing
				for (int i = 0; i < 512; i++)
					resp_q.push_back(image_i[(base + i) % 1024]);
				resp_q.push_back(8'hA5); // crc, never checked
				resp_q.push_back(8'h5A);
				cmd17_cnt_o = cmd17_cnt_o + 4'd1;
			end
			default: resp_q.push_back(8'h04); // illegal command
		endcase
		app_cmd = (frame[0][5:0] == 6'd55);
	endtask

	task automatic take_byte(input logic [7:0] b);
		if (frame_cnt == 0) begin
			if (b[7:6] == 2'b01) begin // start of a command frame
				frame[0] = b;
				frame_cnt = 1;
			end
		end else begin
			frame[frame_cnt] = b;
			frame_cnt++;
			if (frame_cnt == 6) begin
				frame_cnt = 0;
				run_cmd();
			end
		end
	endtask

	always @(posedge sclk_i or negedge sclk_i or posedge reset_i) begin
		if (reset_i) begin
			tx_sh = 8'hFF;
			resp_q.delete();
			bit_cnt = 0;
			frame_cnt = 0;
			app_cmd = 1'b0;
			idle_left = int'(acmd41_idle_i);
			cmd17_cnt_o = '0;
			cmd17_arg_o = '0;
		end else if (sclk_i) begin // rising edge, sample mosi
			rx_sh = {rx_sh[6:0], mosi_i};
			bit_cnt++;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				if (!cs_b_i)
					take_byte(rx_sh);
			end
		end else if (bit_cnt == 0) begin // byte boundary, load next answer
			tx_sh = (resp_q.size() > 0) ? resp_q.pop_front() : 8'hFF;
		end else begin
			tx_sh = {tx_sh[6:0], 1'b1};
		end
	end

endmodule

// ==== tb_sd_ram_loader.sv ====
`timescale 1ns/10ps
`include "sd_loader_params.svh"

module tb_sd_ram_loader import sd_loader_pkg::*; ();

	localparam int byte_cycles = 16 * `SDL_CLK_DIV;   // one spi exchange
	localparam int run_cycles = 2 * (530 + 24 + 8) * byte_cycles;
	localparam int limit = 2 * (2 * run_cycles + 3 * 200 * byte_cycles + 3 * 200);

	logic        clk50;
	logic        reset;
	logic        ram_op_begun_i = 1'b0;
	logic        ram_we_o;
	ram_addr_t   ram_addr_o;
	ram_word_t   ram_data_o;
	logic        done_o, error_o;
	logic        cs_bo, sclk_o, mosi_o, miso_i;

	logic [7:0]  image [0:1023];
	logic [7:0]  token_delay [0:7];
	logic [7:0]  cmd0_resp;
	logic [3:0]  acmd41_idle;
	logic [3:0]  cmd17_cnt;
	logic [31:0] cmd17_arg;

	logic [31:0] lfsr_state;
	logic [31:0] args [$];  // cmd17 arguments seen by the card
	logic [3:0]  seen_cnt;
	int          errors, tests_passed, tests_failed, cycles;
	int          write_count, ack_delay;
	bit          delay_armed, we_seen, err_seen;

	sd_ram_loader_top DUT (
		.clk50(clk50), .reset(reset),
		.ram_we_o(ram_we_o), .ram_addr_o(ram_addr_o), .ram_data_o(ram_data_o),
		.ram_op_begun_i(ram_op_begun_i), .done_o(done_o), .error_o(error_o),
		.cs_bo(cs_bo), .sclk_o(sclk_o), .mosi_o(mosi_o), .miso_i(miso_i)
	);

	tb_sd_card_model card (
		.reset_i(reset), .cs_b_i(cs_bo), .sclk_i(sclk_o), .mosi_i(mosi_o), .miso_o(miso_i),
		.image_i(image), .token_delay_i(token_delay), .cmd0_resp_i(cmd0_resp),
		.acmd41_idle_i(acmd41_idle), .cmd17_cnt_o(cmd17_cnt), .cmd17_arg_o(cmd17_arg)
	);

	initial begin
		clk50 = 1'b0;
		forever #5 clk50 = ~clk50;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// word k holds image bytes 16k..16k+15 with the lowest byte in the low lane
	function automatic ram_word_t expected_word(input int k);
		ram_word_t w;
		for (int b = 0; b < `SDL_WORD_BYTES; b++)
			w[b*8 +: 8] = image[(k * `SDL_WORD_BYTES + b) % 1024];
		return w;
	endfunction

	task automatic check(input string sig, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			$display("Mismatch at %0t: %s expected %h actual %h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: failed", name);
			tests_failed++;
		end
	endtask

	task automatic apply_reset();
		int e;
		@(negedge clk50);
		reset = 1'b1;
		repeat (3) @(negedge clk50);
		e = errors;
		check("ram_we_o", 0, ram_we_o); // outputs still held by reset
		check("done_o", 0, done_o);
		check("error_o", 0, error_o);
		check("sclk_o", 0, sclk_o);
		check("cs_bo", 1, cs_bo);
		check("mosi_o", 1, mosi_o);
		report_test("reset state", e);
		args.delete();
		seen_cnt = '0;
		write_count = 0;
		we_seen = 1'b0;
		err_seen = 1'b0;
		reset = 1'b0;
	endtask

	// ram side with random acknowledge delay and write checking
	always @(negedge clk50) begin
		if (reset) begin
			ram_op_begun_i = 1'b0;
			delay_armed = 1'b0;
		end else if (ram_op_begun_i) begin
			ram_op_begun_i = 1'b0; // one cycle pulse
		end else if (ram_we_o) begin
			if (!delay_armed) begin
				ack_delay = int'(rand_bits(2));
				delay_armed = 1'b1;
			end
			if (ack_delay == 0) begin
				if (write_count >= `SDL_RAM_WORDS) begin
					$display("write beyond the last word at %0t", $time);
					errors++;
				end
				check("ram_addr_o", 128'(ram_addr_t'(`SDL_RAM_BASE + write_count)),
					128'(ram_addr_o));
				check("ram_data_o", expected_word(write_count), ram_data_o);
				write_count++;
				ram_op_begun_i = 1'b1;
				delay_armed = 1'b0;
			end else begin
				ack_delay--;
			end
		end
	end

	always @(negedge clk50) begin
		if (ram_we_o)
			we_seen = 1'b1;
		if (error_o)
			err_seen = 1'b1;
		if (!reset && cmd17_cnt != seen_cnt) begin
			args.push_back(cmd17_arg);
			seen_cnt = cmd17_cnt;
		end
	end

	always @(posedge clk50) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, the load never finished", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic run_load(input logic [3:0] idle_tries, input string name);
		int e;
		bit stuck;
		$display("run: %s", name);
		cmd0_resp = 8'h01;
		acmd41_idle = idle_tries;
		for (int i = 0; i < 8; i++)
			token_delay[i] = 8'(rand_bits(3));
		apply_reset();
		e = errors;
		while (!done_o && !error_o)
			@(negedge clk50);
		report_test("write content", e);
		e = errors;
		check("error_o seen", 0, err_seen);
		check("ram_we_o seen", 1, we_seen);
		report_test("bring-up", e);
		e = errors;
		check("write count", `SDL_RAM_WORDS, write_count);
		report_test("back-pressure", e);
		e = errors;
		check("cmd17 count", 2, args.size());
		for (int i = 0; i < args.size(); i++)
			check("cmd17 argument", i, args[i]);
		report_test("block addressing", e);
		e = errors;
		stuck = 1'b1;
		repeat (200) begin
			@(negedge clk50);
			if (!done_o || ram_we_o)
				stuck = 1'b0;
		end
		check("done_o held, no write", 1, stuck);
		report_test("completion", e);
	endtask

	initial begin
		reset = 1'b0;
		cmd0_resp = 8'h01;
		acmd41_idle = '0;
		lfsr_state = 32'hd0b2c967;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycles = 0;
		for (int i = 0; i < 8; i++)
			token_delay[i] = '0;
		for (int i = 0; i < 1024; i++)
			image[i] = 8'(rand_bits(8));
		run_load(4'd0, "card ready on first acmd41");
		run_load(4'd3, "card idle for three acmd41 tries");
		$display("run: card rejects cmd0");
		cmd0_resp = 8'h05;
		apply_reset();
		begin
			int e;
			e = errors;
			while (!error_o)
				@(negedge clk50);
			repeat (50) @(negedge clk50);
			check("error_o", 1, error_o);
			check("done_o", 0, done_o);
			check("ram_we_o seen", 0, we_seen);
			report_test("error path", e);
		end
		$display("tests passed %0d, failed %0d, mismatches %0d", tests_passed, tests_failed,
			errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
